// File: design/rab_cfg_defines.svh
`ifndef RAB_CFG_DEFINES_SVH
`define RAB_CFG_DEFINES_SVH

// AXI4-Lite bus widths
`define RAB_AXI_DATA_W 64
`define RAB_AXI_ADDR_W 32

// slice field widths
`define RAB_ADDR_VIRT_W 32
`define RAB_ADDR_PHYS_W 40
`define RAB_N_FLAGS 4
`define RAB_MISS_ID_W 10

// word window, slice 0 included
`define RAB_N_SLICES 4
`define RAB_N_WORDS 16
`define RAB_WORD_LSB 3
`define RAB_WORD_IDX_W 4

// miss handling
`define RAB_FIFO_DEPTH 8
`define RAB_WORD_ADDR_FIFO 0
`define RAB_WORD_ID_FIFO 1

`endif

// File: design/rab_axi_pkg.sv
`default_nettype none

`include "rab_cfg_defines.svh"

package rab_axi_pkg;

  // master side of the AXI4-Lite port
  typedef struct packed {
    logic [`RAB_AXI_ADDR_W-1:0]   awaddr;
    logic                         awvalid;
    logic [`RAB_AXI_DATA_W-1:0]   wdata;
    logic [`RAB_AXI_DATA_W/8-1:0] wstrb;
    logic                         wvalid;
    logic                         bready;
    logic [`RAB_AXI_ADDR_W-1:0]   araddr;
    logic                         arvalid;
    logic                         rready;
  } axi_lite_req_t;

  // slave side
  typedef struct packed {
    logic                       awready;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       arready;
    logic [`RAB_AXI_DATA_W-1:0] rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
  } axi_lite_rsp_t;

endpackage

`default_nettype wire

// File: design/rab_cfg_pkg.sv
`default_nettype none

`include "rab_cfg_defines.svh"

package rab_cfg_pkg;

  // one slice word, view picked by idx[1:0]
  typedef union packed {
    struct packed {
      logic [`RAB_AXI_DATA_W-`RAB_ADDR_VIRT_W-1:0] pad;
      logic [`RAB_ADDR_VIRT_W-1:0]                 addr;
    } virt;
    struct packed {
      logic [`RAB_AXI_DATA_W-`RAB_ADDR_PHYS_W-1:0] pad;
      logic [`RAB_ADDR_PHYS_W-1:0]                 addr;
    } phys;
    struct packed {
      logic [`RAB_AXI_DATA_W-`RAB_N_FLAGS-1:0] pad;
      logic [`RAB_N_FLAGS-1:0]                 flags;
    } flags;
    logic [`RAB_AXI_DATA_W-1:0] raw;
  } cfg_word_u;

  typedef struct packed {
    logic                         en;
    logic [`RAB_WORD_IDX_W-1:0]   idx;
    cfg_word_u                    data;
    logic [`RAB_AXI_DATA_W/8-1:0] strb;
  } cfg_wr_t;

  typedef struct packed {
    logic [`RAB_WORD_IDX_W-1:0] idx;
    logic                       pop;
  } cfg_rd_t;

  typedef struct packed {
    logic                        valid;
    logic [`RAB_ADDR_VIRT_W-1:0] addr;
    logic [`RAB_MISS_ID_W-1:0]   id;
  } miss_req_t;

  // empty flag on top, entry right-aligned
  typedef struct packed {
    logic                                          empty;
    logic [`RAB_AXI_DATA_W-`RAB_ADDR_VIRT_W-2:0]   zero;
    logic [`RAB_ADDR_VIRT_W-1:0]                   entry;
  } fifo_rd_word_t;

endpackage

`default_nettype wire

// File: design/miss_fifo.sv
`default_nettype none

`include "rab_cfg_defines.svh"

module miss_fifo #(
  parameter int WIDTH = `RAB_ADDR_VIRT_W,
  parameter int DEPTH = `RAB_FIFO_DEPTH
) (
  input  wire              Clk_CI,
  input  wire              Rst_RBI,
  input  wire              push_i,
  input  wire [WIDTH-1:0]  data_i,
  output logic             full_o,
  input  wire              pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             valid_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push, do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign valid_o = (cnt_q != '0);
  // push to a full FIFO and pop from an empty one are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & valid_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      for (int i = 0; i < DEPTH; i++)
        mem_q[i] <= '0;
    end
    else
    begin
      if (do_push)
      begin
        mem_q[wr_ptr_q] <= data_i;
        wr_ptr_q        <= ptr_inc(wr_ptr_q);
      end
      if (do_pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      cnt_q <= cnt_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  a_cnt_bound: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    cnt_q <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

// File: design/cfg_regfile.sv
`default_nettype none

`include "rab_cfg_defines.svh"

module cfg_regfile (
  input  wire                                       Clk_CI,
  input  wire                                       Rst_RBI,
  input  wire rab_cfg_pkg::cfg_wr_t                 cfg_wr_i,
  input  wire rab_cfg_pkg::cfg_rd_t                 cfg_rd_i,
  output rab_cfg_pkg::cfg_word_u [`RAB_N_WORDS-1:0] l1_cfg_o,
  output logic [`RAB_AXI_DATA_W-1:0]                rdata_o
);

  // slice 0 belongs to the miss handler
  localparam int FIRST_W = `RAB_N_WORDS / `RAB_N_SLICES;

  rab_cfg_pkg::cfg_word_u cfg_q [FIRST_W:`RAB_N_WORDS-1];
  rab_cfg_pkg::cfg_word_u strb_word;
  rab_cfg_pkg::cfg_word_u wr_word;

  always_comb
  begin
    strb_word = '0;
    for (int b = 0; b < `RAB_AXI_DATA_W/8; b++)
      if (cfg_wr_i.strb[b])
        strb_word.raw[8*b +: 8] = cfg_wr_i.data.raw[8*b +: 8];
    // keep only the field of this word's role
    wr_word = '0;
    case (cfg_wr_i.idx[1:0])
      2'b10:   wr_word.phys.addr   = strb_word.phys.addr;
      2'b11:   wr_word.flags.flags = strb_word.flags.flags;
      default: wr_word.virt.addr   = strb_word.virt.addr;
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      for (int w = FIRST_W; w < `RAB_N_WORDS; w++)
        cfg_q[w] <= '0;
    end
    else if (cfg_wr_i.en && (cfg_wr_i.idx >= FIRST_W))
      cfg_q[cfg_wr_i.idx] <= wr_word;
  end

  always_comb
  begin
    l1_cfg_o = '0;
    for (int w = FIRST_W; w < `RAB_N_WORDS; w++)
      l1_cfg_o[w] = cfg_q[w];
  end

  assign rdata_o = l1_cfg_o[cfg_rd_i.idx].raw;

  for (genvar w = FIRST_W; w < `RAB_N_WORDS; w++)
  begin : g_pad_chk
    if ((w % 4) == 3)
    begin : g_flags
      a_pad: assert property (@(posedge Clk_CI) cfg_q[w].flags.pad == '0);
    end
    else if ((w % 4) == 2)
    begin : g_phys
      a_pad: assert property (@(posedge Clk_CI) cfg_q[w].phys.pad == '0);
    end
    else
    begin : g_virt
      a_pad: assert property (@(posedge Clk_CI) cfg_q[w].virt.pad == '0);
    end
  end

endmodule

`default_nettype wire

// File: design/miss_handler.sv
`default_nettype none

`include "rab_cfg_defines.svh"

module miss_handler (
  input  wire                        Clk_CI,
  input  wire                        Rst_RBI,
  input  wire rab_cfg_pkg::miss_req_t miss_i,
  input  wire rab_cfg_pkg::cfg_wr_t  cfg_wr_i,
  input  wire rab_cfg_pkg::cfg_rd_t  cfg_rd_i,
  output logic                       mh_fifo_full_o,
  output logic [`RAB_AXI_DATA_W-1:0] rdata_o
);

  logic                        addr_push, addr_pop, addr_full, addr_valid;
  logic                        id_push, id_pop, id_full, id_valid;
  logic [`RAB_ADDR_VIRT_W-1:0] addr_din, addr_dout;
  logic [`RAB_MISS_ID_W-1:0]   id_din, id_dout;
  rab_cfg_pkg::fifo_rd_word_t  rd_word;

  // a hardware miss takes priority, a colliding software push is lost
  always_comb
  begin
    addr_push = 1'b0;
    id_push   = 1'b0;
    addr_din  = miss_i.addr;
    id_din    = miss_i.id;
    if (miss_i.valid)
    begin
      addr_push = 1'b1;
      id_push   = 1'b1;
    end
    else if (cfg_wr_i.en && (cfg_wr_i.idx == `RAB_WORD_ADDR_FIFO))
    begin
      addr_push = 1'b1;
      addr_din  = cfg_wr_i.data.virt.addr;
    end
    else if (cfg_wr_i.en && (cfg_wr_i.idx == `RAB_WORD_ID_FIFO))
    begin
      id_push = 1'b1;
      id_din  = cfg_wr_i.data.raw[`RAB_MISS_ID_W-1:0];
    end
  end

  assign mh_fifo_full_o = (addr_push & addr_full) | (id_push & id_full);

  always_comb
  begin
    rd_word  = '0;
    addr_pop = 1'b0;
    id_pop   = 1'b0;
    case (cfg_rd_i.idx)
      `RAB_WORD_ADDR_FIFO:
      begin
        rd_word.empty = ~addr_valid;
        rd_word.entry = addr_dout;
        addr_pop      = cfg_rd_i.pop & addr_valid;
      end
      `RAB_WORD_ID_FIFO:
      begin
        rd_word.empty = ~id_valid;
        rd_word.entry = {{(`RAB_ADDR_VIRT_W-`RAB_MISS_ID_W){1'b0}}, id_dout};
        id_pop        = cfg_rd_i.pop & id_valid;
      end
      default:
        rd_word = '0;
    endcase
  end

  assign rdata_o = rd_word;

  miss_fifo #(
    .WIDTH (`RAB_ADDR_VIRT_W),
    .DEPTH (`RAB_FIFO_DEPTH)
  ) addr_fifo (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (addr_push),
    .data_i  (addr_din),
    .full_o  (addr_full),
    .pop_i   (addr_pop),
    .data_o  (addr_dout),
    .valid_o (addr_valid)
  );

  miss_fifo #(
    .WIDTH (`RAB_MISS_ID_W),
    .DEPTH (`RAB_FIFO_DEPTH)
  ) id_fifo (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (id_push),
    .data_i  (id_din),
    .full_o  (id_full),
    .pop_i   (id_pop),
    .data_o  (id_dout),
    .valid_o (id_valid)
  );

endmodule

`default_nettype wire

// File: design/axi_lite_slave.sv
`default_nettype none

`include "rab_cfg_defines.svh"

module axi_lite_slave (
  input  wire                          Clk_CI,
  input  wire                          Rst_RBI,
  input  wire rab_axi_pkg::axi_lite_req_t axi_req_i,
  output rab_axi_pkg::axi_lite_rsp_t   axi_rsp_o,
  output rab_cfg_pkg::cfg_wr_t         cfg_wr_o,
  output rab_cfg_pkg::cfg_rd_t         cfg_rd_o,
  input  wire [`RAB_AXI_DATA_W-1:0]    cfg_rdata_i,
  input  wire [`RAB_AXI_DATA_W-1:0]    mh_rdata_i
);

  localparam int IDX_W = `RAB_WORD_IDX_W;
  localparam int LSB   = `RAB_WORD_LSB;

  // only the word index is kept, upper address bits alias
  logic [IDX_W-1:0]             aw_idx_q;
  logic [IDX_W-1:0]             ar_idx_q;
  logic [`RAB_AXI_DATA_W-1:0]   wdata_q;
  logic [`RAB_AXI_DATA_W/8-1:0] wstrb_q;

  logic awready_q, aw_done_q;
  logic wready_q, w_done_q;
  logic both_dly_q, bvalid_q, b_done_q;
  logic arready_q, ar_done_q, rvalid_q, r_done_q;
  logic both_done, wr_pulse;

  assign both_done = aw_done_q & w_done_q;
  assign wr_pulse  = both_done & ~both_dly_q;

  always_ff @(posedge Clk_CI)
  begin
    if (awready_q && axi_req_i.awvalid)
      aw_idx_q <= axi_req_i.awaddr[LSB +: IDX_W];
    if (wready_q && axi_req_i.wvalid)
    begin
      wdata_q <= axi_req_i.wdata;
      wstrb_q <= axi_req_i.wstrb;
    end
    if (arready_q && axi_req_i.arvalid)
      ar_idx_q <= axi_req_i.araddr[LSB +: IDX_W];
  end

  // AW, W and B channels
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      awready_q  <= 1'b1;
      aw_done_q  <= 1'b0;
      wready_q   <= 1'b1;
      w_done_q   <= 1'b0;
      both_dly_q <= 1'b0;
      bvalid_q   <= 1'b0;
      b_done_q   <= 1'b0;
    end
    else
    begin
      both_dly_q <= both_done;
      if (awready_q && axi_req_i.awvalid)
      begin
        awready_q <= 1'b0;
        aw_done_q <= 1'b1;
      end
      else if (aw_done_q && b_done_q)
      begin
        awready_q <= 1'b1;
        aw_done_q <= 1'b0;
      end
      if (wready_q && axi_req_i.wvalid)
      begin
        wready_q <= 1'b0;
        w_done_q <= 1'b1;
      end
      else if (w_done_q && b_done_q)
      begin
        wready_q <= 1'b1;
        w_done_q <= 1'b0;
      end
      // response runs until bready, then one done cycle
      if (both_done && !b_done_q)
      begin
        if (!bvalid_q)
          bvalid_q <= 1'b1;
        else if (axi_req_i.bready)
        begin
          bvalid_q <= 1'b0;
          b_done_q <= 1'b1;
        end
      end
      else
      begin
        bvalid_q <= 1'b0;
        b_done_q <= 1'b0;
      end
    end
  end

  // AR and R channels
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      arready_q <= 1'b1;
      ar_done_q <= 1'b0;
      rvalid_q  <= 1'b0;
      r_done_q  <= 1'b0;
    end
    else
    begin
      if (arready_q && axi_req_i.arvalid)
      begin
        arready_q <= 1'b0;
        ar_done_q <= 1'b1;
      end
      else if (ar_done_q && r_done_q)
      begin
        arready_q <= 1'b1;
        ar_done_q <= 1'b0;
      end
      if (ar_done_q && !r_done_q)
      begin
        if (!rvalid_q)
          rvalid_q <= 1'b1;
        else if (axi_req_i.rready)
        begin
          rvalid_q <= 1'b0;
          r_done_q <= 1'b1;
        end
      end
      else
      begin
        rvalid_q <= 1'b0;
        r_done_q <= 1'b0;
      end
    end
  end

  always_comb
  begin
    cfg_wr_o.en       = wr_pulse;
    cfg_wr_o.idx      = aw_idx_q;
    cfg_wr_o.data.raw = wdata_q;
    cfg_wr_o.strb     = wstrb_q;
    cfg_rd_o.idx      = ar_idx_q;
    // one pop per completed read
    cfg_rd_o.pop      = rvalid_q & axi_req_i.rready;
  end

  always_comb
  begin
    axi_rsp_o.awready = awready_q;
    axi_rsp_o.wready  = wready_q;
    axi_rsp_o.bresp   = 2'b00;
    axi_rsp_o.bvalid  = bvalid_q;
    axi_rsp_o.arready = arready_q;
    // both sources are zero outside their own words
    axi_rsp_o.rdata   = cfg_rdata_i | mh_rdata_i;
    axi_rsp_o.rresp   = 2'b00;
    axi_rsp_o.rvalid  = rvalid_q;
  end

  a_bvalid_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    bvalid_q && !axi_req_i.bready |=> bvalid_q);

  a_wr_pulse_single: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    wr_pulse |=> !wr_pulse);

endmodule

`default_nettype wire

// File: design/rab_cfg_top.sv
`default_nettype none

`include "rab_cfg_defines.svh"

module rab_cfg_top (
  input  wire                                       Clk_CI,
  input  wire                                       Rst_RBI,
  input  wire rab_axi_pkg::axi_lite_req_t           axi_req_i,
  output rab_axi_pkg::axi_lite_rsp_t                axi_rsp_o,
  input  wire rab_cfg_pkg::miss_req_t               miss_i,
  output logic                                      mh_fifo_full_o,
  output rab_cfg_pkg::cfg_word_u [`RAB_N_WORDS-1:0] l1_cfg_o
);

  rab_cfg_pkg::cfg_wr_t       cfg_wr;
  rab_cfg_pkg::cfg_rd_t       cfg_rd;
  logic [`RAB_AXI_DATA_W-1:0] cfg_rdata;
  logic [`RAB_AXI_DATA_W-1:0] mh_rdata;

  axi_lite_slave u_axi_lite_slave (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .axi_req_i   (axi_req_i),
    .axi_rsp_o   (axi_rsp_o),
    .cfg_wr_o    (cfg_wr),
    .cfg_rd_o    (cfg_rd),
    .cfg_rdata_i (cfg_rdata),
    .mh_rdata_i  (mh_rdata)
  );

  cfg_regfile u_cfg_regfile (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .cfg_wr_i (cfg_wr),
    .cfg_rd_i (cfg_rd),
    .l1_cfg_o (l1_cfg_o),
    .rdata_o  (cfg_rdata)
  );

  miss_handler u_miss_handler (
    .Clk_CI         (Clk_CI),
    .Rst_RBI        (Rst_RBI),
    .miss_i         (miss_i),
    .cfg_wr_i       (cfg_wr),
    .cfg_rd_i       (cfg_rd),
    .mh_fifo_full_o (mh_fifo_full_o),
    .rdata_o        (mh_rdata)
  );

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 4
) (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: sim/tb_rab_cfg.sv
`default_nettype none

`include "rab_cfg_defines.svh"

module tb_rab_cfg;

  localparam int TIMEOUT = 50;
  localparam int DEPTH   = `RAB_FIFO_DEPTH;

  logic                                       Clk_CI;
  logic                                       Rst_RBI;
  rab_axi_pkg::axi_lite_req_t                 axi_req;
  rab_axi_pkg::axi_lite_rsp_t                 axi_rsp;
  rab_cfg_pkg::miss_req_t                     miss;
  logic                                       mh_full;
  rab_cfg_pkg::cfg_word_u [`RAB_N_WORDS-1:0]  l1_cfg;

  // reference model of the words and both FIFOs
  logic [`RAB_AXI_DATA_W-1:0] cfg_model [`RAB_N_WORDS];
  logic [`RAB_ADDR_VIRT_W-1:0] addr_model [$];
  logic [`RAB_MISS_ID_W-1:0]   id_model [$];

  int mismatch_cnt;
  int proto_cnt;
  int timeout_cnt;

  tb_clk_gen #(.PERIOD(4)) clk_gen0 (.clk_o(Clk_CI));

  rab_cfg_top dut0 (
    .Clk_CI         (Clk_CI),
    .Rst_RBI        (Rst_RBI),
    .axi_req_i      (axi_req),
    .axi_rsp_o      (axi_rsp),
    .miss_i         (miss),
    .mh_fifo_full_o (mh_full),
    .l1_cfg_o       (l1_cfg)
  );

  a_bvalid_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    axi_rsp.bvalid && !axi_req.bready |=> axi_rsp.bvalid)
    else
    begin
      proto_cnt++;
      $display("bvalid dropped before bready was seen at time %0t", $time);
    end

  a_rvalid_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    axi_rsp.rvalid && !axi_req.rready |=> axi_rsp.rvalid && $stable(axi_rsp.rdata))
    else
    begin
      proto_cnt++;
      $display("rvalid or rdata changed while rready was low at time %0t", $time);
    end

  task automatic end_run();
    $display("errors: %0d mismatch, %0d protocol, %0d timeout",
             mismatch_cnt, proto_cnt, timeout_cnt);
    if (mismatch_cnt + proto_cnt + timeout_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeout_cnt++;
    $display("Timed out at time %0t while waiting for %s", $time, what);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] got);
    assert (got === exp)
    else
    begin
      mismatch_cnt++;
      $display("Mismatch at time %0t: %s expected 0x%h, got 0x%h", $time, name, exp, got);
    end
  endtask

  // zero-fill by strobe and keep the field of the word's role
  function automatic logic [63:0] masked_word(input logic [3:0] idx,
                                              input logic [63:0] data,
                                              input logic [7:0] strb);
    logic [63:0] keep;
    logic [63:0] mask;
    keep = '0;
    for (int b = 0; b < 8; b++)
      keep[8*b +: 8] = strb[b] ? data[8*b +: 8] : 8'h00;
    case (idx[1:0])
      2'b10:   mask = 64'h0000_00FF_FFFF_FFFF;
      2'b11:   mask = 64'h0000_0000_0000_000F;
      default: mask = 64'h0000_0000_FFFF_FFFF;
    endcase
    return keep & mask;
  endfunction

  task automatic check_cfg_vector();
    for (int w = 0; w < `RAB_N_WORDS; w++)
      check_value($sformatf("l1_cfg_o[%0d]", w), cfg_model[w], l1_cfg[w].raw);
  endtask

  task automatic axi_write(input logic [3:0] idx, input logic [63:0] data,
                           input logic [7:0] strb);
    int n;
    bit aw_hs;
    bit w_hs;
    aw_hs = 1'b0;
    w_hs  = 1'b0;
    // upper address bits are random to exercise aliasing
    axi_req.awaddr  = {25'($urandom), idx, 3'($urandom)};
    axi_req.awvalid = 1'b1;
    axi_req.wdata   = data;
    axi_req.wstrb   = strb;
    axi_req.wvalid  = 1'b1;
    for (n = 0; n < TIMEOUT && !(aw_hs && w_hs); n++)
    begin
      if (axi_rsp.awready && axi_req.awvalid)
        aw_hs = 1'b1;
      if (axi_rsp.wready && axi_req.wvalid)
        w_hs = 1'b1;
      @(posedge Clk_CI);
      #1;
      if (aw_hs)
        axi_req.awvalid = 1'b0;
      if (w_hs)
        axi_req.wvalid = 1'b0;
    end
    if (!(aw_hs && w_hs))
    begin
      report_timeout("the AW and W handshakes");
      return;
    end
    if (idx >= 4)
      cfg_model[idx] = masked_word(idx, data, strb);
    else if (idx == 0 && addr_model.size() < DEPTH)
      addr_model.push_back(data[31:0]);
    else if (idx == 1 && id_model.size() < DEPTH)
      id_model.push_back(data[9:0]);
    for (n = 0; n < TIMEOUT && !axi_rsp.bvalid; n++)
    begin
      @(posedge Clk_CI);
      #1;
    end
    if (!axi_rsp.bvalid)
    begin
      report_timeout("bvalid");
      return;
    end
    check_cfg_vector();
    check_value("bresp", 64'h0, 64'(axi_rsp.bresp));
    repeat ($urandom_range(0, 3))
    begin
      @(posedge Clk_CI);
      #1;
    end
    axi_req.bready = 1'b1;
    @(posedge Clk_CI);
    #1;
    axi_req.bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] idx, output logic [63:0] data);
    int n;
    bit ar_hs;
    ar_hs = 1'b0;
    axi_req.araddr  = {25'($urandom), idx, 3'($urandom)};
    axi_req.arvalid = 1'b1;
    for (n = 0; n < TIMEOUT && !ar_hs; n++)
    begin
      if (axi_rsp.arready)
        ar_hs = 1'b1;
      @(posedge Clk_CI);
      #1;
      if (ar_hs)
        axi_req.arvalid = 1'b0;
    end
    if (!ar_hs)
    begin
      report_timeout("the AR handshake");
      return;
    end
    for (n = 0; n < TIMEOUT && !axi_rsp.rvalid; n++)
    begin
      @(posedge Clk_CI);
      #1;
    end
    if (!axi_rsp.rvalid)
    begin
      report_timeout("rvalid");
      return;
    end
    data = axi_rsp.rdata;
    check_value("rresp", 64'h0, 64'(axi_rsp.rresp));
    repeat ($urandom_range(0, 3))
    begin
      @(posedge Clk_CI);
      #1;
    end
    axi_req.rready = 1'b1;
    @(posedge Clk_CI);
    #1;
    axi_req.rready = 1'b0;
  endtask

  task automatic read_check(input logic [3:0] idx);
    logic [63:0] got;
    axi_read(idx, got);
    case (idx)
      4'd0:
      begin
        // empty read has bit 63 high over a stale entry
        if (addr_model.size() == 0)
          check_value("rdata[63:32] of empty addr FIFO", 64'h8000_0000, 64'(got[63:32]));
        else
          check_value("rdata of addr FIFO", {32'h0, addr_model.pop_front()}, got);
      end
      4'd1:
      begin
        if (id_model.size() == 0)
          check_value("rdata[63:32] of empty ID FIFO", 64'h8000_0000, 64'(got[63:32]));
        else
          check_value("rdata of ID FIFO", {54'h0, id_model.pop_front()}, got);
      end
      4'd2, 4'd3:
        check_value($sformatf("rdata of word %0d", idx), 64'h0, got);
      default:
        check_value($sformatf("rdata of word %0d", idx), cfg_model[idx], got);
    endcase
  endtask

  task automatic push_miss(input logic [31:0] addr, input logic [9:0] id);
    bit exp_full;
    exp_full    = (addr_model.size() >= DEPTH) || (id_model.size() >= DEPTH);
    miss.valid = 1'b1;
    miss.addr  = addr;
    miss.id    = id;
    #1;
    check_value("mh_fifo_full_o", 64'(exp_full), 64'(mh_full));
    if (addr_model.size() < DEPTH)
      addr_model.push_back(addr);
    if (id_model.size() < DEPTH)
      id_model.push_back(id);
    @(posedge Clk_CI);
    #1;
    miss.valid = 1'b0;
  endtask

  initial
  begin
    void'($urandom(86411));
    mismatch_cnt = 0;
    proto_cnt    = 0;
    timeout_cnt  = 0;
    Rst_RBI      = 1'b0;
    axi_req      = '0;
    miss         = '0;
    for (int w = 0; w < `RAB_N_WORDS; w++)
      cfg_model[w] = '0;
    repeat (5) @(posedge Clk_CI);
    #1;
    Rst_RBI = 1'b1;

    // idle state out of reset
    check_value("awready", 64'h1, 64'(axi_rsp.awready));
    check_value("wready", 64'h1, 64'(axi_rsp.wready));
    check_value("arready", 64'h1, 64'(axi_rsp.arready));
    check_value("bvalid", 64'h0, 64'(axi_rsp.bvalid));
    check_value("rvalid", 64'h0, 64'(axi_rsp.rvalid));
    check_value("mh_fifo_full_o", 64'h0, 64'(mh_full));
    check_cfg_vector();

    // slice words with random strobes
    for (int i = 0; i < 24; i++)
      axi_write(4'(4 + $urandom_range(0, 11)), {$urandom, $urandom}, 8'($urandom));
    for (int w = 4; w < `RAB_N_WORDS; w++)
      read_check(4'(w));

    // hardware misses drained past empty
    for (int i = 0; i < 5; i++)
      push_miss($urandom, 10'($urandom));
    for (int i = 0; i < 6; i++)
      read_check(4'd0);
    for (int i = 0; i < 6; i++)
      read_check(4'd1);

    // software pushes through words 0 and 1
    for (int i = 0; i < 3; i++)
    begin
      axi_write(4'd0, {$urandom, $urandom}, 8'hFF);
      axi_write(4'd1, {$urandom, $urandom}, 8'hFF);
    end
    axi_write(4'd2, {$urandom, $urandom}, 8'hFF);
    for (int i = 0; i < 4; i++)
      read_check(4'd0);
    for (int i = 0; i < 4; i++)
      read_check(4'd1);
    read_check(4'd2);
    read_check(4'd3);

    // ninth miss overflows and is dropped
    for (int i = 0; i < DEPTH + 1; i++)
      push_miss($urandom, 10'($urandom));
    for (int i = 0; i < DEPTH + 1; i++)
      read_check(4'd0);
    for (int i = 0; i < DEPTH + 1; i++)
      read_check(4'd1);

    end_run();
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/rab_axi_pkg.sv
design/rab_cfg_pkg.sv
design/miss_fifo.sv
design/cfg_regfile.sv
design/miss_handler.sv
design/axi_lite_slave.sv
design/rab_cfg_top.sv
sim/tb_clk_gen.sv
sim/tb_rab_cfg.sv
